//--- sim/cacc_stimulus.txt
// column 1: layer end digit (0 or 1), then 32 hex digits of word data
// data runs slice 3 down to slice 0, slice 0 is the last 8 digits
0deadbeef0123456789abcdefa5a5a5a5
00000000100000002000000030000000a
0ffffffff00000000ffffffff00000000
03a7c19e25b0d44f1c8e2097a6e1f0b93
0123456789abcdef00fedcba987654321
1cafef00d0badc0de1337c0defeedface
08000000040000000200000001000000f
07ffffffe5555aaaaaaaa555500000001
09c22c7144c17e2a9d0e58b36b2a1f07c
00f0f0f0ff0f0f0f033333333cccccccc
06b8b4567327b23c6643c986966334873
174b0dc5119495cff2ae8944a625558ec
0238e1f2946e87ccd3d1b58ba507ed7ab
02eb141f241b71efb79e2a9e37545e146
0515f007c5bd062c2122008544db127f8
00216231b1f16e9e81190cde766ef438d
0140e0f763352255a109cf92e0ded7263
17fdcc2331befd79f41a7c4c96b68079a

//--- tb.f
design/cacc_pkg.sv
design/dbuf_ram.sv
design/dbuf_ctrl.sv
design/delivery_buffer.sv
design/cacc_delivery_top.sv
sim/cacc_assert.sv
sim/cacc_checker.sv
sim/tb_top.sv

//--- run.sh
#!/bin/sh
# compile and run the delivery stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module tb_top -f tb.f -o tb_sim
if [ $? -ne 0 ]; then
  echo "compile failed"
  exit 1
fi

out=$(./obj_dir/tb_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -q '^>>> PASS$'; then
  exit 0
fi
exit 1

//--- sim/tb_top.sv
/*
 * delivery stage testbench top
 * clock, reset, DUT, words from the stimulus file, random input
 * gaps and output stalls, final verdict
 */

`timescale 1ns/1ps

module tb_top
  import cacc_pkg::*;
();

  localparam int DEPTH    = DEPTH_DFLT;
  localparam int SLICES   = SLICES_DFLT;
  localparam int NWORDS   = 18;
  localparam int WAIT_MAX = 2000;
  // output held low long enough to fill the RAM
  localparam int STALL_CYCLES = 80;

  logic       nvdla_core_clk;
  logic       rst_n;
  logic       acc_valid;
  acc_word_t  acc_word;
  logic       acc_ready;
  logic       sdp_ready;
  logic       sdp_valid;
  sdp_pkt_t   sdp_pkt;
  logic [1:0] done_intr;
  logic       credit_vld;

  // checker side
  logic       end_req;
  logic       end_done;
  int         errors;
  int         words_in;
  int         words_out;
  logic       timed_out;

  // leading digit layer end, then 128 data bits
  logic [131:0] stim_mem [NWORDS];

  initial begin
    nvdla_core_clk = 1'b0;
    forever #2 nvdla_core_clk = ~nvdla_core_clk;
  end

  cacc_delivery_top #(.DEPTH(DEPTH), .SLICES(SLICES)) u_cacc_delivery_top (
    .nvdla_core_clk (nvdla_core_clk),
    .rst_n          (rst_n),
    .acc_valid      (acc_valid),
    .acc_word       (acc_word),
    .sdp_ready      (sdp_ready),
    .acc_ready      (acc_ready),
    .sdp_valid      (sdp_valid),
    .sdp_pkt        (sdp_pkt),
    .done_intr      (done_intr),
    .credit_vld     (credit_vld)
  );

  cacc_checker #(.DEPTH(DEPTH), .SLICES(SLICES)) u_checker (
    .nvdla_core_clk (nvdla_core_clk),
    .rst_n          (rst_n),
    .acc_valid      (acc_valid),
    .acc_ready      (acc_ready),
    .acc_word       (acc_word),
    .sdp_valid      (sdp_valid),
    .sdp_ready      (sdp_ready),
    .sdp_pkt        (sdp_pkt),
    .done_intr      (done_intr),
    .credit_vld     (credit_vld),
    .end_req        (end_req),
    .errors         (errors),
    .words_in       (words_in),
    .words_out      (words_out),
    .end_done       (end_done)
  );

  bind cacc_delivery_top cacc_assert u_cacc_assert (
    .nvdla_core_clk (nvdla_core_clk),
    .rst_n          (rst_n),
    .sdp_valid      (sdp_valid),
    .sdp_ready      (sdp_ready),
    .sdp_pkt        (sdp_pkt),
    .done_intr      (done_intr),
    .credit_vld     (credit_vld)
  );

  // ====================
  // input side
  // ====================

  // one word per iteration, random gap before it
  task automatic send_words();
    int   gap;
    int   wait_cnt;
    logic accepted;
    for (int i = 0; i < NWORDS && !timed_out; i++) begin
      gap = $urandom % 3;
      acc_valid = 1'b0;
      repeat (gap) begin
        @(posedge nvdla_core_clk);
        #1;
      end
      acc_valid = 1'b1;
      acc_word  = acc_word_t'(stim_mem[i][128:0]);
      accepted  = 1'b0;
      wait_cnt  = 0;
      // acc_ready is settled by the falling edge
      while (!accepted && !timed_out) begin
        @(negedge nvdla_core_clk);
        accepted = acc_ready;
        @(posedge nvdla_core_clk);
        #1;
        wait_cnt++;
        if (!accepted && wait_cnt > WAIT_MAX) begin
          $display("timeout: input word %0d was never accepted", i);
          timed_out = 1'b1;
        end
      end
    end
    acc_valid = 1'b0;
  endtask

  // ====================
  // output side
  // ====================

  initial begin
    sdp_ready = 1'b0;
    // reset plus a long stall so back-pressure builds up
    repeat (16 + STALL_CYCLES) @(posedge nvdla_core_clk);
    forever begin
      @(posedge nvdla_core_clk);
      #1;
      sdp_ready = (($urandom % 4) != 0);
    end
  end

  // ====================
  // main sequence
  // ====================

  initial begin
    int wait_cnt;
    rst_n     = 1'b0;
    acc_valid = 1'b0;
    acc_word  = '0;
    end_req   = 1'b0;
    timed_out = 1'b0;
    void'($urandom(32'h9c22_c714));
    $readmemh("sim/cacc_stimulus.txt", stim_mem);
    repeat (16) @(posedge nvdla_core_clk);
    #1 rst_n = 1'b1;

    send_words();

    // drain until every word is out
    wait_cnt = 0;
    while (!timed_out && words_out != NWORDS) begin
      @(negedge nvdla_core_clk);
      wait_cnt++;
      if (wait_cnt > WAIT_MAX) begin
        $display("timeout: only %0d of %0d words were delivered", words_out, NWORDS);
        timed_out = 1'b1;
      end
    end

    if (!timed_out) begin
      // last credit and interrupt land one cycle later
      repeat (4) @(posedge nvdla_core_clk);
      #1 end_req = 1'b1;
      wait_cnt = 0;
      while (!end_done && !timed_out) begin
        @(negedge nvdla_core_clk);
        wait_cnt++;
        if (wait_cnt > WAIT_MAX) begin
          $display("timeout: checker never finished its final checks");
          timed_out = 1'b1;
        end
      end
    end

    $display("summary: errors=%0d timeouts=%0d words_in=%0d words_out=%0d",
             errors, timed_out, words_in, words_out);
    if (errors == 0 && !timed_out) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

//--- sim/cacc_checker.sv
/*
 * delivery stage scoreboard
 * keeps the accepted words, predicts each slice, the layer end flag,
 * the done interrupts and the credits, counts mismatches
 */

`timescale 1ns/1ps

module cacc_checker
  import cacc_pkg::*;
#(
  parameter int DEPTH  = DEPTH_DFLT,
  parameter int SLICES = SLICES_DFLT
) (
  input  logic       nvdla_core_clk,
  input  logic       rst_n,
  input  logic       acc_valid,
  input  logic       acc_ready,
  input  acc_word_t  acc_word,
  input  logic       sdp_valid,
  input  logic       sdp_ready,
  input  sdp_pkt_t   sdp_pkt,
  input  logic [1:0] done_intr,
  input  logic       credit_vld,
  input  logic       end_req,
  output int         errors,
  output int         words_in,
  output int         words_out,
  output logic       end_done
);

  acc_word_t          pend_q[$];
  int                 slice_idx;
  int                 layers_in;
  int                 layers_out;
  int                 credits;
  int                 done_pulses;
  logic [1:0]         exp_done;
  logic               exp_credit;
  logic               saw_full;
  logic [SLICE_W-1:0] exp_data;
  logic               exp_le;
  logic               last;

  task automatic report_mismatch(input string name, input logic [31:0] exp_val,
                                 input logic [31:0] act_val);
    errors++;
    $display("error %s: expected %0h actual %0h at %0t ns", name, exp_val, act_val, $time);
  endtask

  task automatic report_failure(input string what);
    errors++;
    $display("failure at %0t ns: %s", $time, what);
  endtask

  always @(posedge nvdla_core_clk) begin
    if (!rst_n) begin
      pend_q.delete();
      {errors, words_in, words_out, slice_idx} = '0;
      {layers_in, layers_out, credits, done_pulses} = '0;
      exp_done   = 2'b00;
      exp_credit = 1'b0;
      saw_full   = 1'b0;
      end_done   = 1'b0;
    end else begin
      // ====================
      // back-pressure, from the words still pending
      // ====================
      if ((words_in - words_out) < DEPTH && !acc_ready) begin
        report_failure("acc_ready low although the buffer has room");
      end
      if ((words_in - words_out) > DEPTH && acc_ready) begin
        report_failure("acc_ready high with the buffer and output stage full");
      end
      if (!acc_ready) begin
        saw_full = 1'b1;
      end

      // pulses predicted on the previous edge
      if (done_intr !== exp_done) begin
        report_mismatch("done_intr", 32'(exp_done), 32'(done_intr));
      end
      if (credit_vld !== exp_credit) begin
        report_mismatch("credit_vld", 32'(exp_credit), 32'(credit_vld));
      end
      if (done_intr != 2'b00) begin
        done_pulses++;
      end
      if (credit_vld) begin
        credits++;
      end
      exp_done   = 2'b00;
      exp_credit = 1'b0;

      // ====================
      // output slices, low slice first
      // ====================
      if (sdp_valid && sdp_ready) begin
        if (pend_q.size() == 0) begin
          report_failure("slice transferred with no word pending");
        end else begin
          last     = (slice_idx == SLICES - 1);
          exp_data = pend_q[0].data[slice_idx];
          exp_le   = pend_q[0].layer_end & last;
          if (sdp_pkt.data !== exp_data) begin
            report_mismatch("slice_data", exp_data, sdp_pkt.data);
          end
          if (sdp_pkt.layer_end !== exp_le) begin
            report_mismatch("layer_end", 32'(exp_le), 32'(sdp_pkt.layer_end));
          end
          if (last) begin
            exp_credit = 1'b1;
            // odd layers on bit 0, even ones on bit 1
            if (pend_q[0].layer_end) begin
              exp_done = layers_out[0] ? 2'b10 : 2'b01;
              layers_out++;
            end
            void'(pend_q.pop_front());
            slice_idx = 0;
            words_out++;
          end else begin
            slice_idx++;
          end
        end
      end

      // accepted input word
      if (acc_valid && acc_ready) begin
        pend_q.push_back(acc_word);
        words_in++;
        if (acc_word.layer_end) begin
          layers_in++;
        end
      end

      // ====================
      // end of run
      // ====================
      if (end_req && !end_done) begin
        if (pend_q.size() != 0) begin
          report_failure("accepted words were never delivered");
        end
        if (credits != words_out) begin
          report_mismatch("credit_count", 32'(words_out), 32'(credits));
        end
        if (done_pulses != layers_in) begin
          report_mismatch("done_count", 32'(layers_in), 32'(done_pulses));
        end
        if (!saw_full) begin
          report_failure("acc_ready never dropped during the output stall");
        end
        end_done = 1'b1;
      end
    end
  end

endmodule

//--- sim/cacc_assert.sv
/*
 * delivery stage protocol assertions, bound to the top level
 */

`timescale 1ns/1ps

module cacc_assert
  import cacc_pkg::*;
(
  input logic       nvdla_core_clk,
  input logic       rst_n,
  input logic       sdp_valid,
  input logic       sdp_ready,
  input sdp_pkt_t   sdp_pkt,
  input logic [1:0] done_intr,
  input logic       credit_vld
);

  // stalled slice stays put
  a_pkt_hold: assert property (@(posedge nvdla_core_clk) disable iff (!rst_n)
    sdp_valid && !sdp_ready |=> sdp_valid && $stable(sdp_pkt))
    else $error("sdp_pkt changed or dropped while stalled");

  // one bit per done pulse, and only with the credit of the final slice
  a_intr_onehot: assert property (@(posedge nvdla_core_clk) disable iff (!rst_n)
    done_intr != 2'b00 |-> done_intr != 2'b11 && credit_vld)
    else $error("done_intr has both bits set or pulsed without a credit");

  // quiet outputs in reset
  a_reset_quiet: assert property (@(posedge nvdla_core_clk)
    !rst_n |-> !sdp_valid && done_intr == 2'b00 && !credit_vld)
    else $error("output active during reset");

endmodule

//--- design/cacc_delivery_top.sv
/*
 * accumulator delivery stage top
 * controller, storage RAM and slicing output buffer
 */

`timescale 1ns/1ps

module cacc_delivery_top
  import cacc_pkg::*;
#(
  parameter int DEPTH  = DEPTH_DFLT,
  parameter int SLICES = SLICES_DFLT
) (
  input  logic       nvdla_core_clk,
  input  logic       rst_n,
  input  logic       acc_valid,
  input  acc_word_t  acc_word,
  input  logic       sdp_ready,
  output logic       acc_ready,
  output logic       sdp_valid,
  output sdp_pkt_t   sdp_pkt,
  output logic [1:0] done_intr,
  output logic       credit_vld
);

  localparam int AW = $clog2(DEPTH);

  // RAM write side
  logic          wr_en;
  logic [AW-1:0] wr_addr;
  acc_word_t     wr_data;
  // RAM read side
  logic          rd_en;
  logic [AW-1:0] rd_addr;
  acc_word_t     rd_data;
  logic          rd_ready;

  dbuf_ctrl #(.DEPTH(DEPTH)) u_dbuf_ctrl (
    .nvdla_core_clk (nvdla_core_clk),
    .rst_n          (rst_n),
    .acc_valid      (acc_valid),
    .acc_word       (acc_word),
    .rd_ready       (rd_ready),
    .acc_ready      (acc_ready),
    .wr_en          (wr_en),
    .wr_addr        (wr_addr),
    .wr_data        (wr_data),
    .rd_en          (rd_en),
    .rd_addr        (rd_addr)
  );

  dbuf_ram #(.DEPTH(DEPTH)) u_dbuf_ram (
    .nvdla_core_clk (nvdla_core_clk),
    .wr_en          (wr_en),
    .wr_addr        (wr_addr),
    .wr_data        (wr_data),
    .rd_en          (rd_en),
    .rd_addr        (rd_addr),
    .rd_data        (rd_data)
  );

  delivery_buffer #(.SLICES(SLICES)) u_delivery_buffer (
    .nvdla_core_clk (nvdla_core_clk),
    .rst_n          (rst_n),
    .rd_en          (rd_en),
    .rd_data        (rd_data),
    .sdp_ready      (sdp_ready),
    .rd_ready       (rd_ready),
    .sdp_valid      (sdp_valid),
    .sdp_pkt        (sdp_pkt),
    .done_intr      (done_intr),
    .credit_vld     (credit_vld)
  );

endmodule

//--- design/delivery_buffer.sv
/*
 * delivery buffer output stage
 * holds one word from the RAM and sends it slice by slice, lowest
 * first, marks the layer end, alternates done interrupts and
 * returns one credit per delivered word
 */

`timescale 1ns/1ps

module delivery_buffer
  import cacc_pkg::*;
#(
  parameter int SLICES = SLICES_DFLT
) (
  input  logic      nvdla_core_clk,
  input  logic      rst_n,
  input  logic      rd_en,
  input  acc_word_t rd_data,
  input  logic      sdp_ready,
  output logic      rd_ready,
  output logic      sdp_valid,
  output sdp_pkt_t  sdp_pkt,
  output logic [1:0] done_intr,
  output logic      credit_vld
);

  // left mask when only the final slice is pending
  localparam logic [SLICES-1:0] LAST_MASK = {1'b1, {(SLICES-1){1'b0}}};

  logic                                rd_valid;
  logic [SLICES_DFLT-1:0][SLICE_W-1:0] word_data;
  logic                                layer_end_q;
  logic [SLICES-1:0]                   slice_mask;
  logic [SLICES-1:0]                   left_mask;
  logic                                last_slice;
  logic                                sdp_hs;
  logic                                layer_done;
  logic                                intr_sel;

  // ====================
  // word load
  // ====================

  // RAM data is there one cycle after the read
  always_ff @(posedge nvdla_core_clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_valid <= 1'b0;
    end else begin
      rd_valid <= rd_en;
    end
  end

  // data of the word being sliced
  always_ff @(posedge nvdla_core_clk) begin
    if (rd_valid) begin
      word_data <= rd_data.data;
    end
  end

  // idle only with nothing in flight and nothing left
  assign rd_ready = ~rd_valid & ~(|left_mask);

  // ====================
  // slice stepping
  // ====================

  assign sdp_valid  = |left_mask;
  assign sdp_hs     = sdp_valid & sdp_ready;
  assign last_slice = (left_mask == LAST_MASK);

  always_ff @(posedge nvdla_core_clk or negedge rst_n) begin
    if (!rst_n) begin
      slice_mask  <= '0;
      left_mask   <= '0;
      layer_end_q <= 1'b0;
    end else if (rd_valid) begin
      // new word, start at slice 0 with all slices pending
      slice_mask  <= SLICES'(1);
      left_mask   <= '1;
      layer_end_q <= rd_data.layer_end;
    end else if (sdp_hs) begin
      // one-hot walks up, pending bits drain from the bottom
      slice_mask <= slice_mask << 1;
      left_mask  <= left_mask << 1;
    end
  end

  // one-hot select of the current slice
  always_comb begin
    sdp_pkt.data = '0;
    for (int i = 0; i < SLICES; i++) begin
      if (slice_mask[i]) begin
        sdp_pkt.data = sdp_pkt.data | word_data[i];
      end
    end
    // flag only rides on the final slice
    sdp_pkt.layer_end = layer_end_q & last_slice;
  end

  // ====================
  // interrupt and credit
  // ====================

  assign layer_done = sdp_hs & sdp_pkt.layer_end;

  always_ff @(posedge nvdla_core_clk or negedge rst_n) begin
    if (!rst_n) begin
      intr_sel   <= 1'b0;
      done_intr  <= 2'b00;
      credit_vld <= 1'b0;
    end else begin
      // bit 0 for odd layers, bit 1 for even ones
      if (layer_done) begin
        intr_sel <= ~intr_sel;
      end
      done_intr  <= {layer_done & intr_sel, layer_done & ~intr_sel};
      // one entry freed per fully sent word
      credit_vld <= sdp_hs & last_slice;
    end
  end

endmodule

//--- design/dbuf_ctrl.sv
/*
 * delivery buffer controller
 * wrapping write/read pointers and occupancy count, turns accepted
 * words into RAM writes and issues one read per free delivery slot
 */

`timescale 1ns/1ps

module dbuf_ctrl
  import cacc_pkg::*;
#(
  parameter int DEPTH = DEPTH_DFLT
) (
  input  logic                     nvdla_core_clk,
  input  logic                     rst_n,
  input  logic                     acc_valid,
  input  acc_word_t                acc_word,
  input  logic                     rd_ready,
  output logic                     acc_ready,
  output logic                     wr_en,
  output logic [$clog2(DEPTH)-1:0] wr_addr,
  output acc_word_t                wr_data,
  output logic                     rd_en,
  output logic [$clog2(DEPTH)-1:0] rd_addr
);

  localparam int AW = $clog2(DEPTH);
  // count has to reach DEPTH itself
  localparam int CW = $clog2(DEPTH + 1);

  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  logic [CW-1:0] cnt;

  // ====================
  // input side
  // ====================

  // room left in the array
  assign acc_ready = (cnt < CW'(DEPTH));

  // accepted word goes straight into the RAM
  assign wr_en   = acc_valid & acc_ready;
  assign wr_addr = wr_ptr;
  assign wr_data = acc_word;

  // ====================
  // read issue
  // ====================

  // only when a word is stored and the delivery stage is idle
  assign rd_en   = (cnt != '0) & rd_ready;
  assign rd_addr = rd_ptr;

  // ====================
  // pointers and count
  // ====================

  always_ff @(posedge nvdla_core_clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      cnt    <= '0;
    end else begin
      // wrap at DEPTH, not at the power of two
      if (wr_en) begin
        wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (rd_en) begin
        rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      // write and read in the same cycle leave the count alone
      case ({wr_en, rd_en})
        2'b10:   cnt <= cnt + 1'b1;
        2'b01:   cnt <= cnt - 1'b1;
        default: cnt <= cnt;
      endcase
    end
  end

endmodule

//--- design/dbuf_ram.sv
/*
 * delivery buffer storage
 * simple dual-port array, one write port and one read port,
 * read data registered and valid one cycle after rd_en
 */

`timescale 1ns/1ps

module dbuf_ram
  import cacc_pkg::*;
#(
  parameter int DEPTH = DEPTH_DFLT
) (
  input  logic                     nvdla_core_clk,
  input  logic                     wr_en,
  input  logic [$clog2(DEPTH)-1:0] wr_addr,
  input  acc_word_t                wr_data,
  input  logic                     rd_en,
  input  logic [$clog2(DEPTH)-1:0] rd_addr,
  output acc_word_t                rd_data
);

  // storage array, behaves like a RAM macro
  acc_word_t mem [DEPTH];

  // write port
  always_ff @(posedge nvdla_core_clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // read port, output flop holds last word between reads
  always_ff @(posedge nvdla_core_clk) begin
    if (rd_en) begin
      rd_data <= mem[rd_addr];
    end
  end

endmodule

//--- design/cacc_pkg.sv
/*
 * convolution accumulator delivery stage, shared definitions
 * result word, output slice and the default sizes used by the
 * delivery buffer, its controller and the storage RAM
 */

package cacc_pkg;

  // ====================
  // sizes
  // ====================

  // width of one post-processor slice
  localparam int SLICE_W = 32;

  // slices packed into one accumulator result word
  localparam int SLICES_DFLT = 4;

  // delivery buffer entries
  localparam int DEPTH_DFLT = 8;

  // ====================
  // payload types
  // ====================

  // one accumulator result word, slice 0 in the low bits
  // layer_end sits above the data, 129 bits in total
  typedef struct packed {
    logic                                 layer_end;
    logic [SLICES_DFLT-1:0][SLICE_W-1:0]  data;
  } acc_word_t;

  // one slice towards the post-processor, 33 bits
  // layer_end only on the final slice of a layer
  typedef struct packed {
    logic               layer_end;
    logic [SLICE_W-1:0] data;
  } sdp_pkt_t;

endpackage
